// ==== verilog/pucch_pkg.sv ====
`default_nettype none

package pucch_pkg;

  localparam int N_RB_SC     = 12;    // subcarriers per rb, also samples per symbol
  localparam int N_SLOT_SYMB = 14;    // normal cp
  localparam int N_PHASE     = 24;    // phase unit is 1/24 cycle
  localparam int GOLD_NC     = 1600;  // gold sequence offset
  localparam int N_U_GROUPS  = 30;    // base sequence groups

  typedef logic [4:0] phase_t;          // 0..23
  typedef logic [3:0] cs_t;             // cyclic shift 0..11
  typedef logic signed [15:0] sample_t; // sfix16_En15

  typedef struct packed {
    sample_t re;
    sample_t im;
  } iq_t;

  // slot configuration, 45 bits
  typedef struct packed {
    logic       fmt1;       // 1: format 1, 0: format 0
    logic [3:0] sym_start;  // first pucch symbol in slot
    logic [3:0] n_sym;      // allocated symbols
    logic [1:0] ack;        // harq-ack bits, ack[0] first
    logic [1:0] len_ack;    // 0..2
    logic       sr;
    logic       len_sr;
    logic [3:0] m0;         // initial cyclic shift
    logic [7:0] nslot;
    logic [9:0] nid;
    logic [2:0] occi;       // format 1 cover index
    logic [4:0] rsvd;       // zero
  } pucch_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/phase_to_iq.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_to_iq (
  input  wire pucch_pkg::phase_t i_phase,
  output pucch_pkg::iq_t         o_iq
);
  import pucch_pkg::*;

  phase_t sin_idx;

  // round(32767*cos(2*pi*k/24)), second half is the negated first half
  function automatic sample_t cos_q(input phase_t k);
    logic [4:0] idx;
    sample_t    val;
    idx = (k >= 5'd12) ? k - 5'd12 : k;
    case (idx)
      5'd0:  val = 16'sd32767;
      5'd1:  val = 16'sd31650;
      5'd2:  val = 16'sd28377;
      5'd3:  val = 16'sd23170;
      5'd4:  val = 16'sd16384;
      5'd5:  val = 16'sd8481;
      5'd6:  val = 16'sd0;
      5'd7:  val = -16'sd8481;
      5'd8:  val = -16'sd16384;
      5'd9:  val = -16'sd23170;
      5'd10: val = -16'sd28377;
      default: val = -16'sd31650;
    endcase
    cos_q = (k >= 5'd12) ? -val : val;
  endfunction

  assign sin_idx = phase_t'((int'(i_phase) + 18) % N_PHASE);  // sin(x) = cos(x - 90 deg)

  assign o_iq.re = cos_q(i_phase);
  assign o_iq.im = cos_q(sin_idx);

endmodule

`default_nettype wire

// ==== verilog/uci_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module uci_map (
  input  wire pucch_pkg::pucch_cfg_t i_cfg,
  output logic                       o_empty,
  output pucch_pkg::cs_t             o_mcs,
  output pucch_pkg::phase_t          o_mod_phase
);
  import pucch_pkg::*;

  logic       sr_pos;   // positive sr present
  logic [1:0] ack_val;  // 2*ack[0] + ack[1]

  assign sr_pos  = i_cfg.len_sr && i_cfg.sr;
  assign o_empty = (i_cfg.len_ack == 2'd0) && !sr_pos;  // nothing to send
  assign ack_val = {i_cfg.ack[0], i_cfg.ack[1]};

  // format 0 cyclic shift, sr row is offset by 3 (1 bit) or 1 (2 bits)
  always_comb begin
    o_mcs = '0;
    if (!i_cfg.fmt1) begin
      case (i_cfg.len_ack)
        2'd0: o_mcs = '0;
        2'd1: o_mcs = (i_cfg.ack[0] ? 4'd6 : 4'd0) + (sr_pos ? 4'd3 : 4'd0);
        default: begin
          case (ack_val)
            2'b00: o_mcs = 4'd0;
            2'b01: o_mcs = 4'd3;
            2'b10: o_mcs = 4'd9;
            default: o_mcs = 4'd6;
          endcase
          o_mcs = o_mcs + {3'b000, sr_pos};
        end
      endcase
    end
  end

  // format 1 d phase, sr alone is one bit of 0
  always_comb begin
    case (i_cfg.len_ack)
      2'd0: o_mod_phase = 5'd3;
      2'd1: o_mod_phase = i_cfg.ack[0] ? 5'd15 : 5'd3;  // bpsk
      default: begin  // qpsk, b0 b1
        case (ack_val)
          2'b00: o_mod_phase = 5'd3;
          2'b10: o_mod_phase = 5'd9;
          2'b11: o_mod_phase = 5'd15;
          default: o_mod_phase = 5'd21;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/alpha_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module alpha_gen (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire pucch_pkg::pucch_cfg_t i_cfg,
  input  wire pucch_pkg::cs_t        i_mcs,
  input  wire logic                  i_start,
  input  wire logic                  i_next,
  output pucch_pkg::cs_t             o_alpha,
  output logic                       o_alpha_valid
);
  import pucch_pkg::*;

  typedef enum logic [1:0] {A_IDLE, A_SKIP, A_GATHER, A_HOLD} astate_t;

  astate_t     state;
  logic [30:0] x1;         // x1(n) at bit 0
  logic [30:0] x2;
  logic [15:0] skip_cnt;   // steps left before gathering
  logic [15:0] skip_init;  // nc + 112*nslot + 8*l_first
  logic [2:0]  k_cnt;      // bit within ncs
  logic [7:0]  ncs;
  logic        c_bit;
  logic [8:0]  alpha_sum;

  assign c_bit = x1[0] ^ x2[0];
  // f1 starts at the odd symbol after sym_start
  assign skip_init = 16'(GOLD_NC + 8 * N_SLOT_SYMB * i_cfg.nslot
                         + 8 * (i_cfg.sym_start + i_cfg.fmt1));
  assign alpha_sum     = 9'(i_cfg.m0) + 9'(i_mcs) + 9'(ncs);
  assign o_alpha       = cs_t'(alpha_sum % N_RB_SC);  // (m0 + mcs + ncs) mod 12
  assign o_alpha_valid = (state == A_HOLD);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= A_IDLE;
      x1       <= '0;
      x2       <= '0;
      skip_cnt <= '0;
      k_cnt    <= '0;
      ncs      <= '0;
    end else if (i_start) begin
      x1       <= 31'd1;              // 1 then thirty zeros
      x2       <= 31'(i_cfg.nid);     // cinit = nid
      skip_cnt <= skip_init;
      state    <= A_SKIP;
    end else begin
      case (state)
        A_SKIP: begin
          if (skip_cnt == 16'd0) begin
            k_cnt <= '0;
            state <= A_GATHER;
          end else begin
            x1       <= {x1[3] ^ x1[0], x1[30:1]};
            x2       <= {x2[3] ^ x2[2] ^ x2[1] ^ x2[0], x2[30:1]};
            skip_cnt <= skip_cnt - 16'd1;
          end
        end
        A_GATHER: begin
          x1    <= {x1[3] ^ x1[0], x1[30:1]};
          x2    <= {x2[3] ^ x2[2] ^ x2[1] ^ x2[0], x2[30:1]};
          ncs   <= {c_bit, ncs[7:1]};  // first bit ends at lsb
          k_cnt <= k_cnt + 3'd1;
          if (k_cnt == 3'd7) state <= A_HOLD;
        end
        A_HOLD: begin
          if (i_next) begin
            skip_cnt <= i_cfg.fmt1 ? 16'd8 : 16'd0;  // f1 drops the even symbol
            state    <= A_SKIP;
          end
        end
        default: state <= A_IDLE;
      endcase
    end
  end

  // ctrl only asks for the next symbol once this one is held
  a_next_when_valid: assert property (@(posedge clk) disable iff (rst)
    i_next |-> o_alpha_valid);

endmodule

`default_nettype wire

// ==== verilog/base_seq_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module base_seq_rom (
  input  wire pucch_pkg::pucch_cfg_t i_cfg,
  input  wire logic [3:0]            i_n,
  output pucch_pkg::phase_t          o_phase
);
  import pucch_pkg::*;

  logic [23:0] rom [0:N_U_GROUPS-1];  // twelve 2-bit phi codes per group
  logic [4:0]  u;                     // group, no hopping
  logic [23:0] word;
  logic [1:0]  code;

  initial $readmemh("base_seq.hex", rom);

  assign u    = 5'(i_cfg.nid % N_U_GROUPS);
  assign word = rom[u];
  assign code = word[{i_n, 1'b0} +: 2];  // n = 0 at lsb

  // phi -3 -1 1 3 in 24ths
  always_comb begin
    case (code)
      2'd0: o_phase = 5'd15;
      2'd1: o_phase = 5'd21;
      2'd2: o_phase = 5'd3;
      default: o_phase = 5'd9;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/occ_spread.sv ====
`timescale 1ns/1ps
`default_nettype none

module occ_spread (
  input  wire pucch_pkg::pucch_cfg_t i_cfg,
  input  wire logic [2:0]            i_m,
  output pucch_pkg::phase_t          o_phase,
  output logic                       o_supported
);
  import pucch_pkg::*;

  logic [2:0] nsf;   // floor(n_sym/2)
  logic [5:0] prod;  // occi*m, rows of the dft-style covers
  logic       nsf_ok;

  assign nsf    = i_cfg.n_sym[3:1];
  assign prod   = i_cfg.occi * i_m;
  assign nsf_ok = (nsf == 3'd2) || (nsf == 3'd3) || (nsf == 3'd4) || (nsf == 3'd6);

  // lengths 5 and 7 have no exact 24th representation
  assign o_supported = !i_cfg.fmt1 || (nsf_ok && (i_cfg.occi < nsf));

  // phase = 24*phi(m)/nsf
  always_comb begin
    case (nsf)
      3'd2: o_phase = prod[0] ? 5'd12 : 5'd0;           // 00 01
      3'd3: o_phase = phase_t'(8 * (prod % 3));         // 000 012 021
      3'd4: begin
        // 0000 0202 0022 0220, phi is 0 or 2
        if ((i_cfg.occi[0] & i_m[0]) ^ (i_cfg.occi[1] & i_m[1]))
          o_phase = 5'd12;
        else
          o_phase = 5'd0;
      end
      3'd6: o_phase = phase_t'(4 * (prod % 6));         // phi = occi*m mod 6
      default: o_phase = 5'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/pucch_seq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pucch_seq_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  i_start,
  input  wire pucch_pkg::pucch_cfg_t i_cfg,
  output pucch_pkg::pucch_cfg_t      o_cfg,
  input  wire logic                  i_empty,
  input  wire logic                  i_supported,
  input  wire pucch_pkg::phase_t     i_mod_phase,
  output logic                       o_alpha_start,
  output logic                       o_alpha_next,
  input  wire logic                  i_alpha_valid,
  input  wire pucch_pkg::cs_t        i_alpha,
  output logic [3:0]                 o_n,
  output logic [2:0]                 o_m,
  input  wire pucch_pkg::phase_t     i_base_phase,
  input  wire pucch_pkg::phase_t     i_occ_phase,
  output pucch_pkg::iq_t             o_sample,
  output logic                       o_valid,
  output logic                       o_done
);
  import pucch_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_CHECK, S_WAIT_ALPHA, S_GEN, S_DONE} state_t;

  state_t     state;
  pucch_cfg_t cfg_q;
  logic [3:0] n_cnt;      // sample 0..11
  logic [3:0] sym_cnt;    // processed symbols
  logic [3:0] sym_total;  // n_sym for f0, nSF for f1
  logic       last_n;
  logic       last_sym;
  logic       no_tx;      // empty, unsupported or zero symbols
  logic [9:0] phase_raw;  // sum before mod 24
  phase_t     phase;
  iq_t        iq;

  assign sym_total = cfg_q.fmt1 ? {1'b0, cfg_q.n_sym[3:1]} : cfg_q.n_sym;
  assign last_n    = (n_cnt == 4'(N_RB_SC - 1));
  assign last_sym  = (sym_cnt == sym_total - 4'd1);
  assign no_tx     = i_empty || !i_supported || (sym_total == 4'd0);

  assign o_cfg         = cfg_q;
  assign o_n           = n_cnt;
  assign o_m           = sym_cnt[2:0];
  assign o_alpha_start = (state == S_CHECK) && !no_tx;  // one cycle after capture
  assign o_alpha_next  = (state == S_GEN) && last_n && !last_sym;
  // held back while the last sample is still on the output
  assign o_done        = (state == S_DONE) && !o_valid;

  always_comb begin
    phase_raw = 10'(2 * i_alpha * n_cnt) + 10'(i_base_phase);  // 2*alpha*n + base
    if (cfg_q.fmt1) begin
      phase_raw = phase_raw + 10'(i_occ_phase) + 10'(i_mod_phase);  // cover and bpsk/qpsk
    end
    phase = phase_t'(phase_raw % N_PHASE);
  end

  phase_to_iq u_iq (.i_phase(phase), .o_iq(iq));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= S_IDLE;
      cfg_q   <= '0;
      n_cnt   <= '0;
      sym_cnt <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= (state == S_GEN);  // lines up with registered sample
      case (state)
        S_IDLE: begin
          if (i_start) begin
            cfg_q <= i_cfg;
            state <= S_CHECK;
          end
        end
        S_CHECK: begin
          sym_cnt <= '0;
          state   <= no_tx ? S_DONE : S_WAIT_ALPHA;
        end
        S_WAIT_ALPHA: begin
          if (i_alpha_valid) begin
            n_cnt <= '0;
            state <= S_GEN;
          end
        end
        S_GEN: begin
          n_cnt <= n_cnt + 4'd1;
          if (last_n) begin
            n_cnt   <= '0;  // keeps rom index in range between symbols
            sym_cnt <= sym_cnt + 4'd1;
            state   <= last_sym ? S_DONE : S_WAIT_ALPHA;
          end
        end
        S_DONE: begin
          if (!o_valid) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    o_sample <= iq;  // one cycle from phase to sample
  end

  // every sample is formed in generate while alpha_gen holds a valid shift
  a_valid_from_gen: assert property (@(posedge clk) disable iff (rst)
    o_valid |-> $past(state == S_GEN && i_alpha_valid));

  // start is a request from idle only
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    i_start |-> state == S_IDLE);

endmodule

`default_nettype wire

// ==== verilog/pucch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pucch_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  i_start,  // one cycle, only while idle
  input  wire pucch_pkg::pucch_cfg_t i_cfg,    // sampled with i_start
  output pucch_pkg::iq_t             o_sample,
  output logic                       o_valid,
  output logic                       o_done
);
  import pucch_pkg::*;

  pucch_cfg_t cfg;  // captured slot config
  logic       empty;
  logic       supported;
  logic       alpha_start;
  logic       alpha_next;
  logic       alpha_valid;
  cs_t        mcs;
  cs_t        alpha;
  phase_t     mod_phase;
  phase_t     base_phase;
  phase_t     occ_phase;
  logic [3:0] n;  // sample index in symbol
  logic [2:0] m;  // symbol index

  pucch_seq_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .i_start(i_start), .i_cfg(i_cfg), .o_cfg(cfg),
    .i_empty(empty), .i_supported(supported), .i_mod_phase(mod_phase),
    .o_alpha_start(alpha_start), .o_alpha_next(alpha_next),
    .i_alpha_valid(alpha_valid), .i_alpha(alpha),
    .o_n(n), .o_m(m), .i_base_phase(base_phase), .i_occ_phase(occ_phase),
    .o_sample(o_sample), .o_valid(o_valid), .o_done(o_done)
  );

  uci_map u_uci (.i_cfg(cfg), .o_empty(empty), .o_mcs(mcs), .o_mod_phase(mod_phase));

  alpha_gen u_alpha (
    .clk(clk), .rst(rst), .i_cfg(cfg), .i_mcs(mcs),
    .i_start(alpha_start), .i_next(alpha_next),
    .o_alpha(alpha), .o_alpha_valid(alpha_valid)
  );

  base_seq_rom u_base (.i_cfg(cfg), .i_n(n), .o_phase(base_phase));

  occ_spread u_occ (.i_cfg(cfg), .i_m(m), .o_phase(occ_phase), .o_supported(supported));

endmodule

`default_nettype wire

// ==== include/pucch_model.svh ====
`ifndef PUCCH_MODEL_SVH
`define PUCCH_MODEL_SVH

localparam real PI = 3.14159265358979323846;

logic [23:0] model_base [0:29];  // phi codes per group
iq_t         exp_q [$];          // expected samples of the current test

initial $readmemh("base_seq.hex", model_base);

// round half away from zero with a tiny nudge for cos/sin landing just under .5
function automatic int round_q15(input real x);
  real r;
  r = 32767.0 * x;
  if (r >= 0.0) return $rtoi($floor(r + 0.5 + 1.0e-9));
  return -$rtoi($floor(-r + 0.5 + 1.0e-9));
endfunction

function automatic iq_t phase_iq(input int k);
  real ang;
  iq_t v;
  ang  = 2.0 * PI * k / 24.0;
  v.re = sample_t'(round_q15($cos(ang)));
  v.im = sample_t'(round_q15($sin(ang)));
  return v;
endfunction

// ncs(l) straight from the x1/x2 recursions counted from n = 0
function automatic int gold_ncs(input int nid, input int nslot, input int l);
  bit [30:0] x1;
  bit [30:0] x2;
  int        target;
  int        acc;
  x1     = 31'd1;
  x2     = 31'(nid);
  target = GOLD_NC + 8 * N_SLOT_SYMB * nslot + 8 * l;
  acc    = 0;
  for (int n = 0; n < target + 8; n++) begin
    if (n >= target) acc += int'(x1[0] ^ x2[0]) << (n - target);  // bit k weighs 2^k
    x1 = {x1[3] ^ x1[0], x1[30:1]};
    x2 = {x2[3] ^ x2[2] ^ x2[1] ^ x2[0], x2[30:1]};
  end
  return acc;
endfunction

function automatic int f0_shift(input pucch_cfg_t c);
  bit srp;
  int v;
  srp = c.len_sr && c.sr;
  v   = 2 * c.ack[0] + c.ack[1];
  if (c.fmt1 || c.len_ack == 0) return 0;
  if (c.len_ack == 1) return srp ? (c.ack[0] ? 9 : 3) : (c.ack[0] ? 6 : 0);
  if (srp) return (v == 0) ? 1 : (v == 1) ? 4 : (v == 2) ? 10 : 7;
  return (v == 0) ? 0 : (v == 1) ? 3 : (v == 2) ? 9 : 6;
endfunction

function automatic int mod_phase(input pucch_cfg_t c);
  if (c.len_ack == 1) return c.ack[0] ? 15 : 3;  // bpsk with sr alone falling to the end
  if (c.len_ack == 2) begin
    case ({c.ack[0], c.ack[1]})
      2'b00: return 3;
      2'b10: return 9;
      2'b11: return 15;
      default: return 21;
    endcase
  end
  return 3;
endfunction

// cover rows per nsf, one hex digit per symbol with m = 0 leftmost
function automatic int occ_phi(input int nsf, input int occi, input int m);
  logic [23:0] row;
  case (nsf)
    2: row = (occi == 0) ? 24'h00 : 24'h01;
    3: begin
      case (occi)
        0: row = 24'h000;
        1: row = 24'h012;
        default: row = 24'h021;
      endcase
    end
    4: begin
      case (occi)
        0: row = 24'h0000;
        1: row = 24'h0202;
        2: row = 24'h0022;
        default: row = 24'h0220;
      endcase
    end
    default: begin
      case (occi)
        0: row = 24'h000000;
        1: row = 24'h012345;
        2: row = 24'h024024;
        3: row = 24'h030303;
        4: row = 24'h042042;
        default: row = 24'h054321;
      endcase
    end
  endcase
  return int'((row >> (4 * (nsf - 1 - m))) & 24'hf);
endfunction

function automatic int base_phase(input int nid, input int n);
  int phi_tab [4];
  logic [1:0] code;
  phi_tab = '{-3, -1, 1, 3};
  code    = model_base[nid % N_U_GROUPS][2*n +: 2];
  return ((phi_tab[code] * 3) % 24 + 24) % 24;  // phi*pi/4 in 24ths
endfunction

task automatic build_expected(input pucch_cfg_t c);
  int nsymb;
  int l;
  int alpha;
  int occ;
  int d;
  int ph;
  exp_q.delete();
  if (c.len_ack == 0 && !(c.len_sr && c.sr)) return;  // empty
  nsymb = c.fmt1 ? c.n_sym / 2 : c.n_sym;
  if (c.fmt1 && !(nsymb == 2 || nsymb == 3 || nsymb == 4 || nsymb == 6)) return;
  if (c.fmt1 && c.occi >= nsymb) return;
  d = c.fmt1 ? mod_phase(c) : 0;
  for (int m = 0; m < nsymb; m++) begin
    l     = c.fmt1 ? c.sym_start + 2 * m + 1 : c.sym_start + m;
    alpha = (c.m0 + f0_shift(c) + gold_ncs(c.nid, c.nslot, l)) % N_RB_SC;
    occ   = c.fmt1 ? (24 * occ_phi(nsymb, c.occi, m) / nsymb) % 24 : 0;
    for (int n = 0; n < N_RB_SC; n++) begin
      ph = (occ + d + 2 * alpha * n + base_phase(c.nid, n)) % N_PHASE;
      exp_q.push_back(phase_iq(ph));
    end
  end
endtask

`endif

// ==== verification/tb_pucch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pucch;
  import pucch_pkg::*;

  localparam int TIMEOUT = 40000;  // cycles per wait loop
  localparam int N_TESTS = 40;

  logic       clk;
  logic       rst;
  logic       i_start;
  pucch_cfg_t i_cfg;
  iq_t        o_sample;
  logic       o_valid;
  logic       o_done;
  int         errors;
  int         tests_run;
  bit         timed_out;

  `include "pucch_model.svh"

  pucch_top i_dut (
    .clk(clk), .rst(rst), .i_start(i_start), .i_cfg(i_cfg),
    .o_sample(o_sample), .o_valid(o_valid), .o_done(o_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // kind 0 format 0, 1 format 1, 2 empty, 3 unsupported format 1
  task automatic make_cfg(input int kind, output pucch_cfg_t c);
    int nsf_set [4];
    int nsf;
    int sel;
    nsf_set = '{2, 3, 4, 6};
    c       = '0;
    c.nslot = 8'($urandom % 256);
    c.nid   = 10'($urandom % 1024);
    c.m0    = 4'($urandom % 12);
    c.ack   = 2'($urandom % 4);
    case (kind)
      0: begin
        c.n_sym     = 4'(1 + $urandom % 2);
        c.sym_start = 4'($urandom % 13);
        c.len_ack   = 2'($urandom % 3);  // may land on an empty case
        c.len_sr    = 1'($urandom % 2);
        c.sr        = 1'($urandom % 2);
      end
      1: begin
        c.fmt1      = 1'b1;
        nsf         = nsf_set[$urandom % 4];
        c.n_sym     = 4'(2 * nsf + $urandom % 2);
        c.sym_start = 4'($urandom % (15 - c.n_sym));
        c.occi      = 3'($urandom % nsf);
        sel         = $urandom % 3;
        c.len_ack   = 2'((sel == 2) ? 0 : sel + 1);
        c.len_sr    = (sel == 2) ? 1'b1 : 1'($urandom % 2);
        c.sr        = (sel == 2) ? 1'b1 : 1'($urandom % 2);  // sr alone when sel is 2
      end
      2: begin
        c.fmt1   = 1'($urandom % 2);
        c.n_sym  = c.fmt1 ? 4'd4 : 4'(1 + $urandom % 2);
        c.len_sr = 1'($urandom % 2);
        c.sr     = c.len_sr ? 1'b0 : 1'($urandom % 2);  // never a positive sr
      end
      default: begin
        c.fmt1    = 1'b1;
        c.len_ack = 2'd1;
        if ($urandom % 2) begin
          nsf     = ($urandom % 2) ? 5 : 7;
          c.n_sym = 4'(2 * nsf + $urandom % 2);
          c.occi  = 3'($urandom % 8);
        end else begin
          nsf     = nsf_set[$urandom % 4];
          c.n_sym = 4'(2 * nsf);
          c.occi  = 3'(nsf + $urandom % (8 - nsf));  // occi >= nsf
        end
      end
    endcase
  endtask

  task automatic run_test(input int idx, input int kind);
    pucch_cfg_t c;
    int         cyc;
    int         got;
    int         run;
    int         done_cyc;
    int         last_valid;
    int         err0;
    make_cfg(kind, c);
    build_expected(c);
    err0 = errors;
    @(posedge clk);
    i_start <= 1'b1;
    i_cfg   <= c;
    @(posedge clk);
    i_start <= 1'b0;  // captured at this edge
    cyc = 0;
    got = 0;
    run = 0;
    done_cyc   = 0;
    last_valid = 0;
    while (done_cyc == 0 && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (o_valid) begin
        if (got >= exp_q.size()) begin
          $display("test %0d: sample %0d arrived but none expected", idx, got);
          errors++;
        end else if (o_sample !== exp_q[got]) begin
          $display("MISMATCH o_sample test %0d sample %0d got %h expected %h",
                   idx, got, o_sample, exp_q[got]);
          errors++;
        end
        got++;
        run++;
        last_valid = cyc;
      end else if (run != 0) begin
        if (run != N_RB_SC) begin
          $display("test %0d: symbol had %0d consecutive samples, not 12", idx, run);
          errors++;
        end
        run = 0;
      end
      if (o_done) done_cyc = cyc;
    end
    if (done_cyc == 0) begin
      $display("test %0d: no done pulse within %0d cycles", idx, TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end else begin
      if (got != exp_q.size()) begin
        $display("test %0d: %0d samples before done, expected %0d", idx, got, exp_q.size());
        errors++;
      end
      // empty cases finish two cycles after capture and others one after the last sample
      if (exp_q.size() == 0 && done_cyc != 2) begin
        $display("test %0d: done came %0d cycles after start, expected 2", idx, done_cyc);
        errors++;
      end
      if (exp_q.size() != 0 && done_cyc != last_valid + 1) begin
        $display("test %0d: done not one cycle after the last sample", idx);
        errors++;
      end
      @(negedge clk);
      if (o_done) begin
        $display("test %0d: done stayed high for more than one cycle", idx);
        errors++;
      end
    end
    tests_run++;
    $display("test %0d kind %0d fmt%0d nsym %0d samples %0d/%0d %s", idx, kind, c.fmt1,
             c.n_sym, got, exp_q.size(), (errors == err0) ? "ok" : "bad");
  endtask

  initial begin
    void'($urandom(32'h429376b8));
    errors    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    i_start   = 1'b0;
    i_cfg     = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // quiet outputs with no start
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (o_valid || o_done) begin
        $display("idle check: output strobe high without a start");
        errors++;
      end
    end
    $display("idle check %s", (errors == 0) ? "ok" : "bad");
    for (int t = 0; t < N_TESTS; t++) begin
      if (!timed_out) run_test(t, t % 4);
    end
    $display("tests %0d errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== base_seq.hex ====
// one line per group u = 0..29, twelve 2-bit phi codes, n = 0 in the lowest two bits
02a3d0
9c4e71
5b1f26
e60d93
31c8ae
8f2574
d4b90c
2a6e5f
7d0193
c35ab8
461fe2
b9872d
0ce4a6
f15839
6a2dc1
93b04e
28f7d5
e5436a
57ac18
ba1e93
1d69f4
847b2c
cf0536
3ae8d1
f6924b
49cd07
a0578e
6c3af2
d71b65
1582ec

// ==== list.f ====
+incdir+include
verilog/pucch_pkg.sv
verilog/phase_to_iq.sv
verilog/uci_map.sv
verilog/alpha_gen.sv
verilog/base_seq_rom.sv
verilog/occ_spread.sv
verilog/pucch_seq_ctrl.sv
verilog/pucch_top.sv
verification/tb_pucch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pucch testbench with verilator, run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_pucch -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_pucch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
